//--- tb.f
source/fetch_pkg.sv
source/isa_pkg.sv
source/opcode_decode.sv
source/next_state.sv
source/rep_check.sv
source/fetch_ctrl.sv
source/fetch_unit.sv
bench/tb_fetch_unit.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - files:
      - source/fetch_pkg.sv
      - source/isa_pkg.sv
      - source/opcode_decode.sv
      - source/next_state.sv
      - source/rep_check.sv
      - source/fetch_ctrl.sv
      - source/fetch_unit.sv
  - target: test
    files:
      - bench/tb_fetch_unit.sv

//--- bench/tb_fetch_unit.sv
`timescale 1ns/1ps

module tb_fetch_unit;
  import fetch_pkg::*;
  import isa_pkg::*;

  logic              clk, rst;
  logic [WORD_W-1:0] cs, ip, data;
  logic              of, zf, cx_zero, block, intr, ifl;
  ir_t               ir;
  logic [WORD_W-1:0] off, imm;
  logic [ADDR_W-1:0] pc;
  logic              bytefetch, fetch_or_exec, wr_ip0, inta;

  logic [7:0]        mem [logic [ADDR_W-1:0]];  // sparse byte memory
  logic [WORD_W-1:0] pend;  // ip step owed by the cycle in progress
  int                errors;
  int                hits;
  int                t;

  fetch_unit u_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic end_in_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_check(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
    end_in_failure();
  endtask

  task automatic timeout_on(input string what);
    $display("timed out waiting for %s", what);
    end_in_failure();
  endtask

  // unloaded bytes read as one-byte opcodes that decode as nop, picked by address parity
  function automatic logic [7:0] read_byte(input logic [ADDR_W-1:0] a);
    return mem.exists(a) ? mem[a] : ((^a) ? 8'hf4 : OP_NOP);
  endfunction

  task automatic drive_data();
    logic [ADDR_W-1:0] a;
    a = {cs, 4'h0} + ADDR_W'(ip);
    data = {read_byte(a + 1'b1), read_byte(a)};
  endtask

  // ip steps by the imm of the cycle just ended
  task automatic step();
    @(negedge clk);
    ip = ip + pend;
    block = ($urandom % 5) == 0;
    drive_data();
    #1;
    pend = (!block && !fetch_or_exec) ? imm : '0;
  endtask

  task automatic wait_exec_end(input string what);
    int n;
    n = 0;
    while (fetch_or_exec)
    begin
      n++;
      if (n > 50)
        timeout_on(what);
      step();
    end
  endtask

  // code holds the bytes lowest first and word_mask marks the word-sized fetch cycles
  task automatic run_instr(input logic [39:0] code, input int nfetch,
                           input logic [7:0] word_mask, input logic [7:0] wr_mask,
                           input ir_t exp_ir, input logic [15:0] exp_off,
                           input logic [15:0] exp_imm);
    logic [ADDR_W-1:0] base;
    int                nbytes;
    int                n;
    int                i;
    nbytes = nfetch + $countones(word_mask);
    mem.delete();
    cs = 16'($urandom);
    ip = 16'($urandom % 16'hff00);
    base = {cs, 4'h0} + ADDR_W'(ip);
    for (i = 0; i < nbytes; i++)
      mem[base + ADDR_W'(i)] = code[8*i +: 8];
    drive_data();
    #1;
    pend = (!block && !fetch_or_exec) ? imm : '0;
    wait_exec_end("the previous execute to end");
    n = 0;
    i = 0;
    while (!fetch_or_exec)
    begin
      i++;
      if (i > 50)
        timeout_on("the execute state");
      if (!block)
      begin
        assert (n < nfetch) else fail_check("more fetch cycles than fields");
        assert (imm == (word_mask[n] ? 16'd2 : 16'd1) && bytefetch == !word_mask[n])
          else fail_check($sformatf("cycle %0d imm %0d bytefetch %0b", n, imm, bytefetch));
        assert (wr_ip0 == wr_mask[n])
          else fail_check($sformatf("cycle %0d wr_ip0 %0b", n, wr_ip0));
        n++;
      end
      step();
    end
    assert (n == nfetch) else fail_check($sformatf("%0d fetch cycles, not %0d", n, nfetch));
    assert (ir == exp_ir) else fail_check($sformatf("ir %h, expected %h", ir, exp_ir));
    assert (off == exp_off && imm == exp_imm)
      else fail_check($sformatf("off %h imm %h, expected %h %h", off, imm, exp_off, exp_imm));
    assert (!inta) else fail_check("inta in a plain execute");
  endtask

  // real mode address wraps at 1 MB
  assert property (@(posedge clk) int'(pc) == (int'(cs) * 16 + int'(ip)) % (1 << ADDR_W))
    else fail_check("pc is not cs*16+ip");
  assert property (@(posedge clk) disable iff (rst)
    block |=> $stable(u_dut.u_fetch_ctrl.state) && $stable(fetch_or_exec) && $stable(ir)
              && $stable(bytefetch) && $stable(imm) && $stable(wr_ip0) && $stable(inta))
    else fail_check("outputs moved under block");
  assert property (@(posedge clk) disable iff (rst) inta |-> ir.cls == op_int)
    else fail_check("inta without op_int in ir");
  assert property (@(posedge clk) disable iff (rst) (inta && !block) |=> !inta)
    else fail_check("inta longer than one cycle");

  initial
  begin
    void'($urandom(32'h52d6));
    rst = 1'b1;
    cs = '0;
    ip = '0;
    data = 16'h0090;
    of = 1'b0;
    zf = 1'b1;  // f3 repeats while zf is set so only cx ends a repeat
    cx_zero = 1'b0;
    block = 1'b0;
    intr = 1'b0;
    ifl = 1'b0;
    pend = '0;
    errors = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    assert (fetch_or_exec && ir.cls == op_nop && !inta) else fail_check("no nop after reset");

    run_instr(40'h90, 1, 8'h00, 8'h01, ir_t'{op_nop, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h0);
    run_instr(40'hf0458b, 3, 8'h00, 8'h01, ir_t'{op_mov_rm, 1'b1, SEG_DS, 1'b0},
              16'hfff0, 16'h0);  // signed byte offset under mod 01
    run_instr(40'h12348689, 3, 8'h04, 8'h01, ir_t'{op_mov_rm, 1'b1, SEG_DS, 1'b0},
              16'h1234, 16'h0);
    run_instr(40'h56780688, 3, 8'h04, 8'h01, ir_t'{op_mov_rm, 1'b0, SEG_DS, 1'b0},
              16'h5678, 16'h0);  // direct address
    run_instr(40'hc088, 2, 8'h00, 8'h01, ir_t'{op_mov_rm, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h0);
    run_instr(40'habcdb8, 2, 8'h02, 8'h01, ir_t'{op_mov_imm, 1'b1, SEG_DS, 1'b0},
              16'h0, 16'habcd);
    run_instr(40'h80b1, 2, 8'h00, 8'h01, ir_t'{op_mov_imm, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h80);
    run_instr(40'h112205, 2, 8'h02, 8'h01, ir_t'{op_add_acc, 1'b1, SEG_DS, 1'b0},
              16'h0, 16'h1122);
    run_instr(40'h7f04, 2, 8'h00, 8'h01, ir_t'{op_add_acc, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h7f);
    run_instr(40'ha5, 1, 8'h00, 8'h01, ir_t'{op_movs, 1'b1, SEG_DS, 1'b0}, 16'h0, 16'h0);
    run_instr(40'hf4, 1, 8'h00, 8'h01, ir_t'{op_nop, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h0);

    // es then ss segment overrides
    run_instr(40'hfe468b26, 4, 8'h00, 8'h01, ir_t'{op_mov_rm, 1'b1, 2'b00, 1'b0},
              16'hfffe, 16'h0);
    run_instr(40'h55b036, 3, 8'h00, 8'h01, ir_t'{op_mov_imm, 1'b0, 2'b10, 1'b0}, 16'h0, 16'h55);

    // rep movs with cx already zero falls through to the nop behind it
    cx_zero = 1'b1;
    run_instr(40'h90a4f3, 3, 8'h00, 8'h05, ir_t'{op_nop, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h0);
    cx_zero = 1'b0;

    run_instr(40'ha5f3, 2, 8'h00, 8'h01, ir_t'{op_movs, 1'b1, SEG_DS, 1'b1}, 16'h0, 16'h0);
    repeat (3)
    begin
      step();
      assert (fetch_or_exec) else fail_check("rep movs left execute with cx nonzero");
    end
    cx_zero = 1'b1;
    wait_exec_end("rep movs to finish");
    cx_zero = 1'b0;

    intr = 1'b1;
    ifl = 1'b1;
    run_instr(40'h90, 1, 8'h00, 8'h01, ir_t'{op_nop, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h0);
    t = 0;
    while (!(inta && !block))
    begin
      t++;
      if (t > 20)
        timeout_on("inta");
      step();
    end
    intr = 1'b0;
    hits = 0;
    repeat (10)
    begin
      step();
      if (inta && !block)
        hits++;
    end
    assert (hits == 0) else fail_check("second inta for one request");

    ifl = 1'b0;  // masked
    intr = 1'b1;
    run_instr(40'h90, 1, 8'h00, 8'h01, ir_t'{op_nop, 1'b0, SEG_DS, 1'b0}, 16'h0, 16'h0);
    hits = 0;
    repeat (10)
    begin
      step();
      if (inta)
        hits++;
    end
    assert (hits == 0) else fail_check("inta with ifl low");
    intr = 1'b0;

    if (errors == 0)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
      end_in_failure();
  end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [fetch_pkg::WORD_W-1:0] cs,
  input  logic [fetch_pkg::WORD_W-1:0] ip,
  input  logic [fetch_pkg::WORD_W-1:0] data,
  input  logic                         of,
  input  logic                         zf,
  input  logic                         cx_zero,
  input  logic                         block,
  input  logic                         intr,
  input  logic                         ifl,
  output isa_pkg::ir_t                 ir,
  output logic [fetch_pkg::WORD_W-1:0] off,
  output logic [fetch_pkg::WORD_W-1:0] imm,
  output logic [fetch_pkg::ADDR_W-1:0] pc,
  output logic                         bytefetch,
  output logic                         fetch_or_exec,
  output logic                         wr_ip0,
  output logic                         inta
);

  // of feeds the overflow trap, which this front end does not implement
  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cs            (cs),
    .ip            (ip),
    .data          (data),
    .zf            (zf),
    .cx_zero       (cx_zero),
    .block         (block),
    .intr          (intr),
    .ifl           (ifl),
    .ir            (ir),
    .off           (off),
    .imm           (imm),
    .pc            (pc),
    .bytefetch     (bytefetch),
    .fetch_or_exec (fetch_or_exec),
    .wr_ip0        (wr_ip0),
    .inta          (inta)
  );

endmodule

//--- source/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [fetch_pkg::WORD_W-1:0] cs,
  input  logic [fetch_pkg::WORD_W-1:0] ip,
  input  logic [fetch_pkg::WORD_W-1:0] data,
  input  logic                         zf,
  input  logic                         cx_zero,
  input  logic                         block,
  input  logic                         intr,
  input  logic                         ifl,
  output isa_pkg::ir_t                 ir,
  output logic [fetch_pkg::WORD_W-1:0] off,
  output logic [fetch_pkg::WORD_W-1:0] imm,
  output logic [fetch_pkg::ADDR_W-1:0] pc,
  output logic                         bytefetch,
  output logic                         fetch_or_exec,
  output logic                         wr_ip0,
  output logic                         inta
);
  import fetch_pkg::*;
  import isa_pkg::*;

  fetch_state_t      state;
  fetch_state_t      next_st;
  logic [7:0]        opcode, opcode_l;
  logic [7:0]        modrm, modrm_l;
  logic [WORD_W-1:0] off_l, imm_l, imm_d;
  logic [1:0]        pref_l;  // {rep seen, zf sense}
  logic [2:0]        sop_l;   // {override seen, segment}
  ir_t               rom_ir;
  logic              exec_st, sovr_pr, repz_pr, prefix;
  logic              need_modrm, need_off, need_imm, off_size, imm_size;
  logic              end_seq, ext_int, next_in_opco, next_in_exec;

  opcode_decode u_decode (
    .clk(clk), .rst(rst), .block(block),
    .opcode(opcode), .modrm(modrm), .off_l(off_l), .imm_l(imm_l),
    .exec_st(exec_st), .sop(sop_l), .rep_pr(pref_l[1]), .intr(intr), .ifl(ifl),
    .need_modrm(need_modrm), .need_off(need_off), .need_imm(need_imm),
    .off_size(off_size), .imm_size(imm_size), .rom_ir(rom_ir),
    .off(off), .imm_d(imm_d), .end_seq(end_seq), .ext_int(ext_int), .inta(inta)
  );

  next_state u_next_state (
    .state(state), .prefix(prefix),
    .need_modrm(need_modrm), .need_off(need_off), .need_imm(need_imm),
    .end_seq(end_seq), .next_in_opco(next_in_opco), .next_in_exec(next_in_exec),
    .block(block), .intr(intr), .ifl(ifl), .next_st(next_st)
  );

  rep_check u_rep_check (
    .rep_l(pref_l), .opcode7(opcode[7:1]), .cx_zero(cx_zero), .zf(zf),
    .ext_int(ext_int), .next_in_opco(next_in_opco), .next_in_exec(next_in_exec)
  );

  assign pc = {cs, 4'h0} + ADDR_W'(ip);

  // current byte while it is on the bus, latched copy afterwards
  assign opcode = (state == opcod_st) ? data[7:0] : opcode_l;
  assign modrm  = (state == modrm_st) ? data[7:0] : modrm_l;

  assign sovr_pr = (opcode[7:5] == SOVR_HI) && (opcode[2:0] == SOVR_LO);
  assign repz_pr = (opcode[7:1] == OP_REP);
  assign prefix  = sovr_pr || repz_pr;

  assign exec_st       = (state == execu_st);
  assign fetch_or_exec = exec_st;
  assign ir            = exec_st ? rom_ir : IR_ADD_IP;
  assign wr_ip0        = (state == opcod_st) && !pref_l[1] && !sop_l[2];

  assign bytefetch = (state == offse_st) ? !off_size :
                     (state == immed_st) ? !imm_size : 1'b1;

  // ip step while fetching
  assign imm = exec_st ? imm_d :
               (((state == offse_st) && off_size) || ((state == immed_st) && imm_size))
               ? WORD_W'(2) : WORD_W'(1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= execu_st;
      opcode_l <= OP_NOP;  // one nop execute out of reset
      pref_l   <= 2'b00;
      sop_l    <= 3'b000;
    end
    else if (!block)
    begin
      state <= next_st;
      if (state == opcod_st)
        opcode_l <= data[7:0];
      if ((state == opcod_st) && prefix)
      begin
        if (repz_pr)
          pref_l <= {1'b1, opcode[0]};
        if (sovr_pr)
          sop_l <= {1'b1, opcode[4:3]};
      end
      else if (next_st == opcod_st)
      begin
        pref_l <= 2'b00;  // instruction done
        sop_l  <= 3'b000;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!block)
    begin
      case (state)
        modrm_st: modrm_l <= data[7:0];
        offse_st: off_l   <= data;
        immed_st: imm_l   <= data;
        default: ;
      endcase
      // fields left unfetched read as zero
      if (next_st == opcod_st)
      begin
        off_l <= '0;
        imm_l <= '0;
      end
    end
  end

endmodule

//--- source/rep_check.sv
`timescale 1ns/1ps

module rep_check (
  input  logic [1:0] rep_l,    // {rep seen, zf sense}
  input  logic [6:0] opcode7,  // opcode without width bit
  input  logic       cx_zero,
  input  logic       zf,
  input  logic       ext_int,
  output logic       next_in_opco,
  output logic       next_in_exec
);
  import isa_pkg::*;

  logic rep_movs;
  logic zf_exit;

  assign rep_movs = rep_l[1] && (opcode7 == OP_MOVS);
  assign zf_exit  = (zf != rep_l[0]);  // repz stops on zf clear, repnz on zf set

  // nothing to move, go straight to the next opcode
  assign next_in_opco = rep_movs && cx_zero;

  // another round unless the count ran out, zf says stop or an interrupt cuts in
  assign next_in_exec = rep_movs && !cx_zero && !zf_exit && !ext_int;

endmodule

//--- source/next_state.sv
`timescale 1ns/1ps

module next_state (
  input  fetch_pkg::fetch_state_t state,
  input  logic                    prefix,
  input  logic                    need_modrm,
  input  logic                    need_off,
  input  logic                    need_imm,
  input  logic                    end_seq,
  input  logic                    next_in_opco,
  input  logic                    next_in_exec,
  input  logic                    block,
  input  logic                    intr,
  input  logic                    ifl,
  output fetch_pkg::fetch_state_t next_st
);
  import fetch_pkg::*;

  fetch_state_t after_modrm;
  logic         stay_exec;

  assign after_modrm = need_off ? offse_st : (need_imm ? immed_st : execu_st);

  // rep continues, or an interrupt is taken at the boundary
  assign stay_exec = next_in_exec || (end_seq && intr && ifl);

  always_comb
  begin
    next_st = state;  // frozen under block
    if (!block)
    begin
      case (state)
        opcod_st:
          if (prefix || next_in_opco)  // prefix, or rep with cx already zero
            next_st = opcod_st;
          else if (need_modrm)
            next_st = modrm_st;
          else if (need_imm)
            next_st = immed_st;
          else
            next_st = execu_st;
        modrm_st:
          next_st = after_modrm;
        offse_st:
          next_st = need_imm ? immed_st : execu_st;
        immed_st:
          next_st = execu_st;
        execu_st:
          next_st = stay_exec ? execu_st : opcod_st;
        default:
          next_st = opcod_st;
      endcase
    end
  end

endmodule

//--- source/opcode_decode.sv
`timescale 1ns/1ps

module opcode_decode (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            block,
  input  logic [7:0]                      opcode,
  input  logic [7:0]                      modrm,
  input  logic [fetch_pkg::WORD_W-1:0]    off_l,
  input  logic [fetch_pkg::WORD_W-1:0]    imm_l,
  input  logic                            exec_st,
  input  logic [2:0]                      sop,     // {override seen, segment}
  input  logic                            rep_pr,
  input  logic                            intr,
  input  logic                            ifl,
  output logic                            need_modrm,
  output logic                            need_off,
  output logic                            need_imm,
  output logic                            off_size,  // 1 = word
  output logic                            imm_size,  // 1 = word
  output isa_pkg::ir_t                    rom_ir,
  output logic [fetch_pkg::WORD_W-1:0]    off,
  output logic [fetch_pkg::WORD_W-1:0]    imm_d,
  output logic                            end_seq,
  output logic                            ext_int,
  output logic                            inta
);
  import fetch_pkg::*;
  import isa_pkg::*;

  logic [1:0] md;
  logic [2:0] rm;
  logic       mov_imm;
  logic       add_acc;
  logic       movs;
  op_class_t  op_cls;

  assign md = modrm[7:6];
  assign rm = modrm[2:0];

  assign need_modrm = (opcode[7:2] == OP_MOV_RM);
  assign mov_imm    = (opcode[7:4] == OP_MOV_IMM);
  assign add_acc    = (opcode[7:1] == OP_ADD_ACC);
  assign movs       = (opcode[7:1] == OP_MOVS);

  assign need_imm = mov_imm || add_acc;
  // width bit is bit 3 for mov reg,imm and bit 0 for the rest
  assign imm_size = mov_imm ? opcode[3] : opcode[0];

  // mod 10 and direct address take a word, mod 01 a byte
  assign off_size = (md == 2'b10) || (md == 2'b00 && rm == 3'b110);
  assign need_off = need_modrm && (md == 2'b01 || off_size);

  // byte displacement is signed, byte immediate is not
  assign off   = off_size ? off_l : {{(WORD_W-8){off_l[7]}}, off_l[7:0]};
  assign imm_d = imm_size ? imm_l : {{(WORD_W-8){1'b0}}, imm_l[7:0]};

  always_comb
  begin
    if (ext_int)
      op_cls = op_int;  // interrupt entry replaces the opcode
    else if (need_modrm)
      op_cls = op_mov_rm;
    else if (mov_imm)
      op_cls = op_mov_imm;
    else if (add_acc)
      op_cls = op_add_acc;
    else if (movs)
      op_cls = op_movs;
    else
      op_cls = op_nop;  // undefined opcodes too
  end

  assign rom_ir = '{cls:  op_cls,
                    wide: imm_size,
                    seg:  sop[2] ? sop[1:0] : SEG_DS,
                    rep:  rep_pr};

  // an instruction ends here, the interrupt entry cycle does not count
  assign end_seq = exec_st && !ext_int;

  always_ff @(posedge clk)
  begin
    if (rst)
      ext_int <= 1'b0;
    else if (!block)
      ext_int <= end_seq && intr && ifl;  // taken at the boundary only
  end

  assign inta = exec_st && ext_int;

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

  // operation classes seen by the core
  typedef enum logic [3:0] {
    op_nop     = 4'd0,
    op_mov_rm  = 4'd1,
    op_mov_imm = 4'd2,
    op_add_acc = 4'd3,
    op_movs    = 4'd4,
    op_int     = 4'd5,
    op_add_ip  = 4'd6
  } op_class_t;

  // micro-instruction word
  typedef struct packed {
    op_class_t  cls;   // operation class
    logic       wide;  // word operand
    logic [1:0] seg;   // data segment in effect
    logic       rep;   // rep prefix pending
  } ir_t;

  localparam logic [7:0] OP_NOP     = 8'h90;
  localparam logic [6:0] OP_REP     = 7'b1111_001;  // f2/f3, bit 0 is the zf sense
  localparam logic [6:0] OP_MOVS    = 7'b1010_010;  // a4/a5
  localparam logic [5:0] OP_MOV_RM  = 6'b1000_10;   // 88..8b
  localparam logic [3:0] OP_MOV_IMM = 4'b1011;      // b0..bf
  localparam logic [6:0] OP_ADD_ACC = 7'b0000_010;  // 04/05

  // segment override prefix is 001s_s110
  localparam logic [2:0] SOVR_HI = 3'b001;
  localparam logic [2:0] SOVR_LO = 3'b110;

  localparam logic [1:0] SEG_DS = 2'b11;  // default data segment

  // shown while fetching, lets the core step ip
  localparam ir_t IR_ADD_IP = '{cls: op_add_ip, wide: 1'b0, seg: SEG_DS, rep: 1'b0};

endpackage

//--- source/fetch_pkg.sv
package fetch_pkg;

  // physical address, 20 bits in real mode
  localparam int ADDR_W = 20;

  // data bus, offsets and immediates
  localparam int WORD_W = 16;

  // fetch walk of one instruction; each non-execute state takes one cycle
  typedef enum logic [2:0] {
    opcod_st = 3'h0,  // opcode or prefix byte
    modrm_st = 3'h1,  // modrm byte
    offse_st = 3'h2,  // displacement, byte or word
    immed_st = 3'h3,  // immediate, byte or word
    execu_st = 3'h4   // execute
  } fetch_state_t;

endpackage
